// File: logic/bridgePkg.sv
`default_nettype none

package bridgePkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;
  typedef logic [1:0]  htransT;

  // AHB transfer type codes.
  localparam htransT htransIdle   = 2'b00;
  localparam htransT htransBusy   = 2'b01;
  localparam htransT htransNonseq = 2'b10;
  localparam htransT htransSeq    = 2'b11;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // peripheral slot map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int numSlots = 3;

  typedef logic [numSlots-1:0] slotSelT;

  localparam addrT slotBase0 = 32'h0100_0400;
  localparam addrT slotBase1 = 32'h0100_0800;
  localparam addrT slotBase2 = 32'h0100_0c00;
  localparam addrT slotSpan  = 32'h0000_0400;

  typedef enum logic [2:0] {
    stIdle,
    stReadSetup,
    stReadAccess,
    stWriteData,
    stWriteSetup,
    stWriteAccess
  } bridgeStateT;

endpackage

`default_nettype wire

// File: logic/bridgeCtrlIf.sv
`default_nettype none
`timescale 1ns/10ps

// strobes and phase flags from the bridge FSM to the datapath.
interface bridgeCtrlIf;
  logic loadAddr;
  logic loadWdata;
  logic loadRdata;
  logic apbActive;
  logic apbAccess;

  modport ctrl (
    output loadAddr,
    output loadWdata,
    output loadRdata,
    output apbActive,
    output apbAccess
  );

  modport data (
    input loadAddr,
    input loadWdata,
    input loadRdata,
    input apbActive,
    input apbAccess
  );
endinterface

`default_nettype wire

// File: logic/bridgeControl.sv
`default_nettype none
`timescale 1ns/10ps

module bridgeControl (
  input  logic              Jal5h,
  input  logic              Oal5h,
  input  logic              hsel,
  input  logic              hready,
  input  logic              hwrite,
  input  logic              pclkEn,
  input  bridgePkg::htransT htrans,
  bridgeCtrlIf.ctrl         ctrl,
  output logic              hreadyResp,
  output logic              penable,
  output logic              pwrite
);
  import bridgePkg::*;

  bridgeStateT state;
  bridgeStateT stateNext;
  logic        transValid;
  logic        accept;

  // only NONSEQ and SEQ carry a real transfer.
  assign transValid = (htrans == htransNonseq) || (htrans == htransSeq);

  // a transfer is taken only while the bridge itself signals ready.
  assign accept = hsel && hready && hreadyResp && transValid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (accept) begin
          stateNext = hwrite ? stWriteData : stReadSetup;
        end
      end
      stReadSetup: begin
        if (pclkEn) begin
          stateNext = stReadAccess;
        end
      end
      stReadAccess: begin
        if (pclkEn) begin
          stateNext = stIdle;
        end
      end
      // write data arrives one cycle after the address phase.
      stWriteData: begin
        stateNext = stWriteSetup;
      end
      stWriteSetup: begin
        if (pclkEn) begin
          stateNext = stWriteAccess;
        end
      end
      stWriteAccess: begin
        if (pclkEn) begin
          stateNext = stIdle;
        end
      end
      default: begin
        stateNext = stIdle;
      end
    endcase
  end

  always_ff @(posedge Jal5h or negedge Oal5h) begin
    if (!Oal5h) begin
      state      <= stIdle;
      hreadyResp <= 1'b1;
      penable    <= 1'b0;
    end else begin
      state      <= stateNext;
      hreadyResp <= (stateNext == stIdle);
      penable    <= (stateNext == stReadAccess) || (stateNext == stWriteAccess);
    end
  end

  // pwrite stays put after the transfer until a new one is accepted.
  always_ff @(posedge Jal5h or negedge Oal5h) begin
    if (!Oal5h) begin
      pwrite <= 1'b0;
    end else if (accept) begin
      pwrite <= 1'b0;
    end else if (state == stWriteData) begin
      pwrite <= 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign ctrl.loadAddr  = accept;
  assign ctrl.loadWdata = (state == stWriteData);
  assign ctrl.loadRdata = (state == stReadAccess) && pclkEn;

  assign ctrl.apbActive = (state == stReadSetup) || (state == stReadAccess) ||
                          (state == stWriteSetup) || (state == stWriteAccess);
  assign ctrl.apbAccess = (state == stReadAccess) || (state == stWriteAccess);

endmodule

`default_nettype wire

// File: logic/transferRegs.sv
`default_nettype none
`timescale 1ns/10ps

module transferRegs (
  input  logic            Jal5h,
  input  logic            Oal5h,
  input  bridgePkg::addrT haddr,
  input  bridgePkg::dataT hwdata,
  input  bridgePkg::dataT slotRdata,
  bridgeCtrlIf.data       regs,
  output bridgePkg::addrT paddr,
  output bridgePkg::dataT pwdata,
  output bridgePkg::dataT hrdata
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AHB side to APB side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // address is captured in the AHB address phase and drives paddr directly.
  always_ff @(posedge Jal5h or negedge Oal5h) begin
    if (!Oal5h) begin
      paddr <= '0;
    end else if (regs.loadAddr) begin
      paddr <= haddr;
    end
  end

  // hwdata is valid in the cycle after the address phase.
  always_ff @(posedge Jal5h or negedge Oal5h) begin
    if (!Oal5h) begin
      pwdata <= '0;
    end else if (regs.loadWdata) begin
      pwdata <= hwdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB side to AHB side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // read data is sampled at the end of the access phase and held for the master.
  always_ff @(posedge Jal5h or negedge Oal5h) begin
    if (!Oal5h) begin
      hrdata <= '0;
    end else if (regs.loadRdata) begin
      hrdata <= slotRdata;
    end
  end

endmodule

`default_nettype wire

// File: logic/apbSlotDecode.sv
`default_nettype none
`timescale 1ns/10ps

module apbSlotDecode (
  input  bridgePkg::addrT paddr,
  input  bridgePkg::dataT prdataS0,
  input  bridgePkg::dataT prdataS1,
  input  bridgePkg::dataT prdataS2,
  bridgeCtrlIf.data       sel,
  output logic            pselS0,
  output logic            pselS1,
  output logic            pselS2,
  output bridgePkg::dataT slotRdata
);
  import bridgePkg::*;

  slotSelT slotSel;

  function automatic logic inSlot(input addrT addr, input addrT base);
    inSlot = (addr >= base) && (addr < (base + slotSpan));
  endfunction

  assign slotSel[0] = inSlot(paddr, slotBase0);
  assign slotSel[1] = inSlot(paddr, slotBase1);
  assign slotSel[2] = inSlot(paddr, slotBase2);

  // psel covers both the setup and the access phase.
  assign pselS0 = slotSel[0] && sel.apbActive;
  assign pselS1 = slotSel[1] && sel.apbActive;
  assign pselS2 = slotSel[2] && sel.apbActive;

  // the slaves only present read data in the access phase. An unmapped
  // address reads as zero.
  always_comb begin
    slotRdata = '0;
    if (sel.apbAccess) begin
      if (slotSel[0]) begin
        slotRdata = prdataS0;
      end else if (slotSel[1]) begin
        slotRdata = prdataS1;
      end else if (slotSel[2]) begin
        slotRdata = prdataS2;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/ahbApbBridge.sv
`default_nettype none
`timescale 1ns/10ps

module ahbApbBridge (
  input  logic              Jal5h,
  input  logic              Oal5h,
  input  logic              hsel,
  input  logic              hready,
  input  logic              hwrite,
  input  bridgePkg::htransT htrans,
  input  bridgePkg::addrT   haddr,
  input  bridgePkg::dataT   hwdata,
  output logic              hreadyResp,
  output logic [1:0]        hresp,
  output bridgePkg::dataT   hrdata,
  input  logic              pclkEn,
  input  bridgePkg::dataT   prdataS0,
  input  bridgePkg::dataT   prdataS1,
  input  bridgePkg::dataT   prdataS2,
  output bridgePkg::addrT   paddr,
  output bridgePkg::dataT   pwdata,
  output logic              pwrite,
  output logic              penable,
  output logic              pselS0,
  output logic              pselS1,
  output logic              pselS2
);
  import bridgePkg::*;

  dataT slotRdata;

  bridgeCtrlIf ctrlBus ();

  // the bridge never signals an error, so the response is always OKAY.
  assign hresp = 2'b00;

  bridgeControl uControl (
    .Jal5h      (Jal5h),
    .Oal5h      (Oal5h),
    .hsel       (hsel),
    .hready     (hready),
    .hwrite     (hwrite),
    .pclkEn     (pclkEn),
    .htrans     (htrans),
    .ctrl       (ctrlBus.ctrl),
    .hreadyResp (hreadyResp),
    .penable    (penable),
    .pwrite     (pwrite)
  );

  transferRegs uRegs (
    .Jal5h     (Jal5h),
    .Oal5h     (Oal5h),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .slotRdata (slotRdata),
    .regs      (ctrlBus.data),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .hrdata    (hrdata)
  );

  apbSlotDecode uDecode (
    .paddr     (paddr),
    .prdataS0  (prdataS0),
    .prdataS1  (prdataS1),
    .prdataS2  (prdataS2),
    .sel       (ctrlBus.data),
    .pselS0    (pselS0),
    .pselS1    (pselS1),
    .pselS2    (pselS2),
    .slotRdata (slotRdata)
  );

endmodule

`default_nettype wire

// File: verif/clockGen.sv
`default_nettype none
`timescale 1ns/10ps

module clockGen (
  output logic Jal5h,
  output logic Oal5h
);

  initial begin
    Jal5h = 1'b0;
    forever begin
      #10 Jal5h = ~Jal5h;
    end
  end

  // reset is released away from the clock edge.
  initial begin
    Oal5h = 1'b0;
    repeat (4) @(posedge Jal5h);
    #5 Oal5h = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/tbAhbApbBridge.sv
`default_nettype none
`timescale 1ns/10ps

module tbAhbApbBridge;
  import bridgePkg::*;

  logic   Jal5h, Oal5h, hsel, hready, hwrite, pclkEn;
  htransT htrans;
  addrT   haddr, paddr;
  dataT   hwdata, hrdata, pwdata, prdataS0, prdataS1, prdataS2;
  logic   hreadyResp, pwrite, penable, pselS0, pselS1, pselS2;
  logic [1:0] hresp;
  logic        randMode;
  logic [31:0] lfsr;

  clockGen uClock (.Jal5h(Jal5h), .Oal5h(Oal5h));

  ahbApbBridge dut (
    .Jal5h(Jal5h), .Oal5h(Oal5h), .hsel(hsel), .hready(hready), .hwrite(hwrite),
    .htrans(htrans), .haddr(haddr), .hwdata(hwdata), .hreadyResp(hreadyResp),
    .hresp(hresp), .hrdata(hrdata), .pclkEn(pclkEn), .prdataS0(prdataS0),
    .prdataS1(prdataS1), .prdataS2(prdataS2), .paddr(paddr), .pwdata(pwdata),
    .pwrite(pwrite), .penable(penable), .pselS0(pselS0), .pselS1(pselS1),
    .pselS2(pselS2)
  );

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    lfsrStep = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // slots are 1 KiB each, starting at 0x0100_0400.
  function automatic int slotOf(input addrT a);
    slotOf = -1;
    if (a >= 32'h0100_0400 && a < 32'h0100_1000) begin
      slotOf = int'((a - 32'h0100_0400) >> 10);
    end
  endfunction

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic checkAddr(input string name, input addrT got, input addrT exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkData(input string name, input dataT got, input dataT exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  // pclkEn is random inside the marked block of the stimulus file.
  initial begin
    pclkEn = 1'b1;
    lfsr = 32'h42c6_8468;
    forever begin
      @(posedge Jal5h);
      if (randMode) begin
        lfsr = lfsrStep(lfsr);
        pclkEn <= lfsr[0];
      end else begin
        pclkEn <= 1'b1;
      end
    end
  end

  task automatic runTransfer(input logic isWrite, input htransT kindCode, input addrT addr,
                             input dataT value, input dataT expRead);
    int   slot;
    int   cycles;
    logic sawAccess;
    slot = slotOf(addr);
    sawAccess = 1'b0;
    @(posedge Jal5h);
    hsel     <= 1'b1;
    htrans   <= kindCode;
    hwrite   <= isWrite;
    haddr    <= addr;
    prdataS0 <= (slot == 0) ? value : ~value;
    prdataS1 <= (slot == 1) ? value : ~value;
    prdataS2 <= (slot == 2) ? value : ~value;
    // this edge accepts the transfer.
    @(posedge Jal5h);
    hsel   <= 1'b0;
    htrans <= htransIdle;
    hwdata <= value;
    cycles = 1;
    forever begin
      @(negedge Jal5h);
      checkResp("hresp", hresp, 2'b00);
      if (hreadyResp) begin
        break;
      end
      cycles++;
      if (cycles > 200) begin
        failNow("timeout waiting for hreadyResp to rise");
      end
      if (penable) begin
        sawAccess = 1'b1;
        checkBit("pselS0", pselS0, slot == 0);
        checkBit("pselS1", pselS1, slot == 1);
        checkBit("pselS2", pselS2, slot == 2);
        checkBit("pwrite", pwrite, isWrite);
        checkAddr("paddr", paddr, addr);
        if (isWrite) begin
          checkData("pwdata", pwdata, value);
        end
      end
    end
    if (!sawAccess) begin
      failNow("transfer completed without an APB access phase");
    end
    if (!isWrite) begin
      checkData("hrdata", hrdata, expRead);
    end
    if (!randMode && cycles != (isWrite ? 4 : 3)) begin
      failNow($sformatf("transfer took %0d cycles instead of %0d", cycles, isWrite ? 4 : 3));
    end
  endtask

  // a request that must not start any APB phase.
  task automatic runIgnored(input logic selIn, input htransT kindCode, input addrT addr);
    @(posedge Jal5h);
    hsel   <= selIn;
    htrans <= kindCode;
    hwrite <= 1'b0;
    haddr  <= addr;
    repeat (3) begin
      @(negedge Jal5h);
      checkBit("hreadyResp", hreadyResp, 1'b1);
      checkResp("hresp", hresp, 2'b00);
      checkBit("penable", penable, 1'b0);
      checkBit("pselS0", pselS0, 1'b0);
      checkBit("pselS1", pselS1, 1'b0);
      checkBit("pselS2", pselS2, 1'b0);
    end
    @(posedge Jal5h);
    hsel   <= 1'b0;
    htrans <= htransIdle;
  endtask

  initial begin
    int fd;
    int waitCount;
    string line;
    logic [63:0] kind;
    addrT addr;
    dataT value, expRead;
    hsel = 1'b0;
    hready = 1'b1;
    hwrite = 1'b0;
    htrans = htransIdle;
    haddr = '0;
    hwdata = '0;
    prdataS0 = '0;
    prdataS1 = '0;
    prdataS2 = '0;
    randMode = 1'b0;
    waitCount = 0;
    while (Oal5h !== 1'b1) begin
      @(posedge Jal5h);
      waitCount++;
      if (waitCount > 50) begin
        failNow("reset was never released");
      end
    end
    @(negedge Jal5h);
    checkBit("hreadyResp", hreadyResp, 1'b1);
    checkResp("hresp", hresp, 2'b00);
    checkBit("penable", penable, 1'b0);
    checkBit("pwrite", pwrite, 1'b0);
    checkBit("pselS0", pselS0, 1'b0);
    checkBit("pselS1", pselS1, 1'b0);
    checkBit("pselS2", pselS2, 1'b0);
    checkAddr("paddr", paddr, '0);
    checkData("pwdata", pwdata, '0);
    checkData("hrdata", hrdata, '0);
    fd = $fopen("verif/bridgeStimulus.txt", "r");
    if (fd == 0) begin
      failNow("cannot open the stimulus file verif/bridgeStimulus.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if ($sscanf(line, "%s %h %h %h", kind, addr, value, expRead) != 4) begin
        failNow({"malformed stimulus line: ", line});
      end
      if (kind == "wr") begin
        runTransfer(1'b1, htransNonseq, addr, value, expRead);
      end else if (kind == "rd") begin
        runTransfer(1'b0, htransNonseq, addr, value, expRead);
      end else if (kind == "rdseq") begin
        runTransfer(1'b0, htransSeq, addr, value, expRead);
      end else if (kind == "idle") begin
        runIgnored(1'b1, htransIdle, addr);
      end else if (kind == "busy") begin
        runIgnored(1'b1, htransBusy, addr);
      end else if (kind == "nosel") begin
        runIgnored(1'b0, htransNonseq, addr);
      end else if (kind == "rand") begin
        // the pclkEn source changes between clock edges.
        @(negedge Jal5h);
        randMode = 1'b1;
      end else if (kind == "fixed") begin
        @(negedge Jal5h);
        randMode = 1'b0;
      end else begin
        failNow({"unknown transfer kind in line: ", line});
      end
    end
    $fclose(fd);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/bridgeStimulus.txt
# kind address value expected_hrdata (hex)
# value is hwdata for writes and the selected slot's prdata for reads
wr 01000400 a5a50001 00000000
wr 01000804 a5a50002 00000000
wr 01000ffc a5a50003 00000000
rd 01000410 12340000 12340000
rd 01000800 12340001 12340001
rdseq 01000c08 12340002 12340002
rd 02000000 deadbeef 00000000
wr 01001000 0badf00d 00000000
idle 01000400 00000000 00000000
busy 01000800 00000000 00000000
nosel 01000c00 00000000 00000000
rand 00000000 00000000 00000000
wr 01000bfc 5a5a0004 00000000
rd 010007fc 87654321 87654321
rd 000003fc cafef00d 00000000
wr 01000c40 5a5a0005 00000000
fixed 00000000 00000000 00000000
rd 01000bfc 0f0f0f0f 0f0f0f0f

// File: verilog.f
logic/bridgePkg.sv
logic/bridgeCtrlIf.sv
logic/bridgeControl.sv
logic/transferRegs.sv
logic/apbSlotDecode.sv
logic/ahbApbBridge.sv
verif/clockGen.sv
verif/tbAhbApbBridge.sv

// File: Makefile
TOP := tbAhbApbBridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)
	verilator --lint-only --timing logic/bridgePkg.sv logic/bridgeCtrlIf.sv \
		logic/bridgeControl.sv logic/transferRegs.sv logic/apbSlotDecode.sv \
		logic/ahbApbBridge.sv --top-module ahbApbBridge

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
